// File: verilog.f
source/filter_pkg.sv
source/stream_if.sv
source/request_if.sv
source/request_decoder.sv
source/pattern_matcher.sv
source/packet_queue.sv
source/forward_control.sv
source/regex_filter_top.sv
sim/tb_regex_filter.sv

// File: Makefile
# Verilator simulation of the packet filter

TOP       ?= tb_regex_filter
VERILATOR ?= verilator
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) 2>&1 | tee $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_regex_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_regex_filter;
    import filter_pkg::*;

    localparam int DATA_BYTES = 8;
    localparam int PAT_BYTES = 4;
    localparam int MAX_LEN = 40;
    localparam int NUM_DIRECTED = 7;
    localparam int NUM_RANDOM = 60;
    // Upper bound on beats driven over the whole run
    localparam int TOTAL_BEATS = (NUM_DIRECTED + NUM_RANDOM) * (MAX_LEN / DATA_BYTES);
    localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 500;
    localparam int NOTICE_LEN = 4;
    localparam logic [DATA_BYTES-1:0] NOTICE_KEEP = DATA_BYTES'((1 << NOTICE_LEN) - 1);
    localparam logic [31:0] SEED = 32'hf3ae_8afb;
    // Stream order a1 b2 c3 d4 and e5 f0 8b 9c, all with bit 7 set
    localparam logic [8*PAT_BYTES-1:0] PAT_A = 32'hd4c3_b2a1;
    localparam logic [8*PAT_BYTES-1:0] PAT_B = 32'h9c8b_f0e5;

    typedef struct packed {
        logic [8*DATA_BYTES-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } beat_t;

    typedef struct packed {
        logic [VADDR_BITS-1:0] vaddr;
        logic [LEN_BITS-1:0]   len;
        logic [QP_BITS-1:0]    qp;
    } cmd_t;

    logic                    aclk;
    logic                    aresetn;
    logic                    in_tvalid;
    logic                    in_tready;
    logic [8*DATA_BYTES-1:0] in_tdata;
    logic [DATA_BYTES-1:0]   in_tkeep;
    logic                    in_tlast;
    logic                    out_tvalid;
    logic                    out_tready;
    logic [8*DATA_BYTES-1:0] out_tdata;
    logic [DATA_BYTES-1:0]   out_tkeep;
    logic                    out_tlast;
    logic                    req_valid;
    logic                    req_ready;
    logic [VADDR_BITS-1:0]   req_vaddr;
    logic [LEN_BITS-1:0]     req_len;
    logic [QP_BITS-1:0]      req_qp;
    logic                    cmd_valid;
    logic                    cmd_ready;
    logic [VADDR_BITS-1:0]   cmd_vaddr;
    logic [LEN_BITS-1:0]     cmd_len;
    logic [QP_BITS-1:0]      cmd_qp;
    logic                    cfg_valid;
    logic                    cfg_ready;
    logic [8*PAT_BYTES-1:0]  cfg_pattern;

    beat_t                  exp_out[$];
    cmd_t                   exp_cmd[$];
    cmd_t                   req_q[$];
    logic [7:0]             pkt_bytes [64];
    logic [8*PAT_BYTES-1:0] cur_pattern;
    bit                     random_ready;
    int                     errors;
    int                     beats_seen;
    int                     cmds_seen;
    int                     cycles;

    regex_filter_top uut (.*);

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    task automatic expect_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %0h got %0h", name, exp, act);
            errors++;
        end
    endtask

    // Reference search over the valid packet bytes only
    function automatic bit has_pattern(input int len, input logic [8*PAT_BYTES-1:0] pat);
        bit hit;
        bit same;
        hit = 1'b0;
        for (int s = 0; s + PAT_BYTES <= len; s++) begin
            same = 1'b1;
            for (int k = 0; k < PAT_BYTES; k++) begin
                if (pkt_bytes[s + k] != pat[8*k +: 8]) begin
                    same = 1'b0;
                end
            end
            hit = hit | same;
        end
        return hit;
    endfunction

    task automatic fill_bytes(input logic [7:0] mask);
        for (int i = 0; i < 64; i++) begin
            pkt_bytes[i] = 8'($urandom) & mask;
        end
    endtask

    task automatic plant_pattern(input int offset);
        for (int k = 0; k < PAT_BYTES; k++) begin
            pkt_bytes[offset + k] = cur_pattern[8*k +: 8];
        end
    endtask

    task automatic drive_beat(input beat_t b);
        in_tvalid = 1'b1;
        in_tdata = b.data;
        in_tkeep = b.keep;
        in_tlast = b.last;
        @(posedge aclk);
        while (!in_tready) @(posedge aclk);
        @(negedge aclk);
        in_tvalid = 1'b0;
    endtask

    task automatic load_pattern(input logic [8*PAT_BYTES-1:0] pat);
        cfg_valid = 1'b1;
        cfg_pattern = pat;
        @(posedge aclk);
        while (!cfg_ready) @(posedge aclk);
        @(negedge aclk);
        cfg_valid = 1'b0;
        cur_pattern = pat;
    endtask

    // Queue the request and expectations, then push the beats in
    task automatic send_packet(input int len);
        cmd_t  c;
        beat_t b;
        beat_t notice;
        bit    hit;
        int    beats;
        hit = has_pattern(len, cur_pattern);
        beats = (len + DATA_BYTES - 1) / DATA_BYTES;
        c.vaddr = {16'($urandom), $urandom};
        c.len = LEN_BITS'(len);
        c.qp = QP_BITS'($urandom);
        req_q.push_back(c);
        if (!hit) begin
            c.len = LEN_BITS'(NOTICE_LEN);
            notice.data = '0;
            notice.keep = NOTICE_KEEP;
            notice.last = 1'b1;
            exp_out.push_back(notice);
        end
        exp_cmd.push_back(c);
        for (int i = 0; i < beats; i++) begin
            for (int k = 0; k < DATA_BYTES; k++) begin
                b.data[8*k +: 8] = pkt_bytes[DATA_BYTES*i + k];
                b.keep[k] = (DATA_BYTES*i + k) < len;
            end
            b.last = (i == beats - 1);
            if (hit) begin
                exp_out.push_back(b);
            end
            drive_beat(b);
        end
    endtask

    initial begin : request_driver
        cmd_t r;
        forever begin
            @(negedge aclk);
            while (req_q.size() != 0) begin
                r = req_q.pop_front();
                req_valid = 1'b1;
                req_vaddr = r.vaddr;
                req_len = r.len;
                req_qp = r.qp;
                @(posedge aclk);
                while (!req_ready) @(posedge aclk);
                @(negedge aclk);
                req_valid = 1'b0;
            end
        end
    end

    // Random low periods on both ready inputs
    always @(negedge aclk) begin
        if (random_ready) begin
            out_tready = ($urandom % 4) != 0;
            cmd_ready = ($urandom % 3) != 0;
        end
    end

    always @(posedge aclk) begin : out_monitor
        beat_t b;
        if (aresetn && out_tvalid && out_tready) begin
            if (exp_out.size() == 0) begin
                $display("Output beat transferred while none was expected");
                errors++;
            end else begin
                b = exp_out.pop_front();
                expect_value("out_tdata", 64'(b.data), 64'(out_tdata));
                expect_value("out_tkeep", 64'(b.keep), 64'(out_tkeep));
                expect_value("out_tlast", 64'(b.last), 64'(out_tlast));
                beats_seen++;
            end
        end
    end

    always @(posedge aclk) begin : cmd_monitor
        cmd_t c;
        if (aresetn && cmd_valid && cmd_ready) begin
            if (exp_cmd.size() == 0) begin
                $display("Command issued while no request was outstanding");
                errors++;
            end else begin
                c = exp_cmd.pop_front();
                expect_value("cmd_vaddr", 64'(c.vaddr), 64'(cmd_vaddr));
                expect_value("cmd_len", 64'(c.len), 64'(cmd_len));
                expect_value("cmd_qp", 64'(c.qp), 64'(cmd_qp));
                cmds_seen++;
            end
        end
    end

    // A stalled output beat stays up and unchanged
    assert property (@(posedge aclk) disable iff (!aresetn)
        (out_tvalid && !out_tready) |=>
        (out_tvalid && $stable(out_tdata) && $stable(out_tkeep) && $stable(out_tlast)))
    else begin
        $display("Output beat was withdrawn or changed before it transferred");
        errors++;
    end

    always @(posedge aclk) begin : watchdog
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d beats and %0d commands still expected",
                     cycles, exp_out.size(), exp_cmd.size());
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        int len;
        void'($urandom(SEED));
        errors = 0;
        beats_seen = 0;
        cmds_seen = 0;
        cycles = 0;
        random_ready = 1'b0;
        cur_pattern = '0;
        aresetn = 1'b0;
        in_tvalid = 1'b0;
        in_tdata = '0;
        in_tkeep = '0;
        in_tlast = 1'b0;
        out_tready = 1'b1;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_len = '0;
        req_qp = '0;
        cmd_ready = 1'b1;
        cfg_valid = 1'b0;
        cfg_pattern = '0;
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        expect_value("cfg_ready", 64'(1), 64'(cfg_ready));
        expect_value("req_ready", 64'(1), 64'(req_ready));
        expect_value("out_tvalid", 64'(0), 64'(out_tvalid));
        expect_value("cmd_valid", 64'(0), 64'(cmd_valid));

        load_pattern(PAT_A);
        // Match inside one beat, then a clean drop
        fill_bytes(8'h7f);
        plant_pattern(2);
        send_packet(24);
        fill_bytes(8'h7f);
        send_packet(20);
        // Pattern straddles beats 0 and 1
        fill_bytes(8'h7f);
        plant_pattern(6);
        send_packet(16);
        // Last two pattern bytes sit in lanes with tkeep clear
        fill_bytes(8'h7f);
        plant_pattern(11);
        send_packet(13);
        // Same data under two patterns
        fill_bytes(8'h7f);
        plant_pattern(3);
        send_packet(16);
        load_pattern(PAT_B);
        send_packet(16);
        plant_pattern(9);
        send_packet(30);

        random_ready = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (n == NUM_RANDOM / 2) begin
                load_pattern(PAT_A);
            end
            len = 1 + int'($urandom % MAX_LEN);
            fill_bytes(8'hff);
            if (len >= PAT_BYTES && ($urandom % 2) == 0) begin
                plant_pattern(int'($urandom % (len - PAT_BYTES + 1)));
            end
            send_packet(len);
        end

        while (exp_out.size() != 0 || exp_cmd.size() != 0) @(posedge aclk);
        // Room for any extra transfer to show up
        repeat (20) @(posedge aclk);
        $display("Checked %0d output beats and %0d commands, %0d errors",
                 beats_seen, cmds_seen, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/regex_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module regex_filter_top #(
    parameter int DATA_BYTES = 8,
    parameter int PAT_BYTES = 4,
    parameter int QUEUE_DEPTH = 64
) (
    input  logic                             aclk,
    input  logic                             aresetn,

    // Card memory stream
    input  logic                             in_tvalid,
    output logic                             in_tready,
    input  logic [8*DATA_BYTES-1:0]          in_tdata,
    input  logic [DATA_BYTES-1:0]            in_tkeep,
    input  logic                             in_tlast,

    // RDMA write data
    output logic                             out_tvalid,
    input  logic                             out_tready,
    output logic [8*DATA_BYTES-1:0]          out_tdata,
    output logic [DATA_BYTES-1:0]            out_tkeep,
    output logic                             out_tlast,

    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic [filter_pkg::VADDR_BITS-1:0] req_vaddr,
    input  logic [filter_pkg::LEN_BITS-1:0]   req_len,
    input  logic [filter_pkg::QP_BITS-1:0]    req_qp,

    output logic                             cmd_valid,
    input  logic                             cmd_ready,
    output logic [filter_pkg::VADDR_BITS-1:0] cmd_vaddr,
    output logic [filter_pkg::LEN_BITS-1:0]   cmd_len,
    output logic [filter_pkg::QP_BITS-1:0]    cmd_qp,

    input  logic                             cfg_valid,
    output logic                             cfg_ready,
    input  logic [8*PAT_BYTES-1:0]           cfg_pattern
);

    stream_if #(.DATA_BYTES(DATA_BYTES)) match_in ();
    stream_if #(.DATA_BYTES(DATA_BYTES)) queue_in ();
    stream_if #(.DATA_BYTES(DATA_BYTES)) queue_out ();
    stream_if #(.DATA_BYTES(DATA_BYTES)) out_bus ();
    request_if #(.DATA_BYTES(DATA_BYTES)) req_bus ();

    logic found_valid;
    logic found_ready;
    logic found;

    // Both consumers take a beat together or not at all
    assign in_tready = match_in.tready & queue_in.tready;

    assign match_in.tvalid = in_tvalid & in_tready;
    assign match_in.tdata = in_tdata;
    assign match_in.tkeep = in_tkeep;
    assign match_in.tlast = in_tlast;

    assign queue_in.tvalid = in_tvalid & in_tready;
    assign queue_in.tdata = in_tdata;
    assign queue_in.tkeep = in_tkeep;
    assign queue_in.tlast = in_tlast;

    assign out_tvalid = out_bus.tvalid;
    assign out_tdata = out_bus.tdata;
    assign out_tkeep = out_bus.tkeep;
    assign out_tlast = out_bus.tlast;
    assign out_bus.tready = out_tready;

    request_decoder #(.DATA_BYTES(DATA_BYTES)) u_decoder (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_vaddr (req_vaddr),
        .req_len   (req_len),
        .req_qp    (req_qp),
        .req       (req_bus.src)
    );

    pattern_matcher #(.DATA_BYTES(DATA_BYTES), .PAT_BYTES(PAT_BYTES)) u_matcher (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_pattern (cfg_pattern),
        .data_in     (match_in.dst),
        .found_valid (found_valid),
        .found_ready (found_ready),
        .found       (found)
    );

    packet_queue #(.DATA_BYTES(DATA_BYTES), .QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wr      (queue_in.dst),
        .rd      (queue_out.src)
    );

    forward_control #(.DATA_BYTES(DATA_BYTES)) u_control (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req         (req_bus.dst),
        .found_valid (found_valid),
        .found_ready (found_ready),
        .found       (found),
        .queue       (queue_out.dst),
        .out         (out_bus.src),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_vaddr   (cmd_vaddr),
        .cmd_len     (cmd_len),
        .cmd_qp      (cmd_qp)
    );

endmodule

`default_nettype wire

// File: source/forward_control.sv
`timescale 1ns/1ps
`default_nettype none

module forward_control #(
    parameter int DATA_BYTES = 8
) (
    input  logic                             aclk,
    input  logic                             aresetn,

    request_if.dst                           req,

    input  logic                             found_valid,
    output logic                             found_ready,
    input  logic                             found,

    stream_if.dst                            queue,
    stream_if.src                            out,

    output logic                             cmd_valid,
    input  logic                             cmd_ready,
    output logic [filter_pkg::VADDR_BITS-1:0] cmd_vaddr,
    output logic [filter_pkg::LEN_BITS-1:0]   cmd_len,
    output logic [filter_pkg::QP_BITS-1:0]    cmd_qp
);
    import filter_pkg::*;

    localparam int LAST_BITS = LEN_BITS - $clog2(DATA_BYTES);
    localparam logic [DATA_BYTES-1:0] NOTICE_KEEP =
        DATA_BYTES'((64'd1 << NOTICE_BYTES) - 64'd1);

    fwd_state_t           state;
    logic [LAST_BITS-1:0] beat_cnt;
    logic [LAST_BITS-1:0] last_idx;
    logic                 notice_sent;
    logic                 drained;
    logic                 start;
    logic                 queue_xfer;
    logic                 out_xfer;
    logic                 final_beat;

    // Verdict, request and command slot all needed to start
    assign start = (state == IDLE) && found_valid && req.valid && cmd_ready;

    assign cmd_valid = start;
    assign found_ready = start;
    assign req.ready = start;

    assign cmd_vaddr = req.vaddr;
    assign cmd_qp = req.qp;
    assign cmd_len = found ? req.len : LEN_BITS'(NOTICE_BYTES);

    assign queue_xfer = queue.tvalid & queue.tready;
    assign out_xfer = out.tvalid & out.tready;
    assign final_beat = (beat_cnt == last_idx);

    always_comb begin
        queue.tready = 1'b0;
        out.tvalid = 1'b0;
        out.tdata = queue.tdata;
        out.tkeep = queue.tkeep;
        out.tlast = queue.tlast;
        case (state)
            SEND: begin
                queue.tready = out.tready;
                out.tvalid = queue.tvalid;
            end
            DROP: begin
                // Payload drains at full rate, notice goes out on its own
                queue.tready = ~drained;
                out.tvalid = ~notice_sent;
                out.tdata = '0;
                out.tkeep = NOTICE_KEEP;
                out.tlast = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
            beat_cnt <= '0;
            notice_sent <= 1'b0;
            drained <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        beat_cnt <= '0;
                        notice_sent <= 1'b0;
                        drained <= 1'b0;
                        state <= found ? SEND : DROP;
                    end
                end
                SEND: begin
                    if (queue_xfer) begin
                        if (final_beat) begin
                            state <= IDLE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                DROP: begin
                    if (queue_xfer) begin
                        if (final_beat) begin
                            drained <= 1'b1;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                    if (out_xfer) begin
                        notice_sent <= 1'b1;
                    end
                    if (drained && notice_sent) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            last_idx <= req.last_beat;
        end
    end

endmodule

`default_nettype wire

// File: source/packet_queue.sv
`timescale 1ns/1ps
`default_nettype none

module packet_queue #(
    parameter int DATA_BYTES = 8,
    parameter int QUEUE_DEPTH = 64
) (
    input  logic  aclk,
    input  logic  aresetn,
    stream_if.dst wr,
    stream_if.src rd
);

    localparam int ADDR_BITS = $clog2(QUEUE_DEPTH);

    logic [8*DATA_BYTES-1:0] mem_data [QUEUE_DEPTH];
    logic [DATA_BYTES-1:0]   mem_keep [QUEUE_DEPTH];
    logic                    mem_last [QUEUE_DEPTH];

    // Extra top bit tells full from empty
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;
    logic               full;
    logic               empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
                  (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

    assign wr.tready = ~full;
    assign rd.tvalid = ~empty;

    // Head entry read straight out of the array
    assign rd.tdata = mem_data[rd_ptr[ADDR_BITS-1:0]];
    assign rd.tkeep = mem_keep[rd_ptr[ADDR_BITS-1:0]];
    assign rd.tlast = mem_last[rd_ptr[ADDR_BITS-1:0]];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.tvalid && wr.tready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.tvalid && rd.tready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr.tvalid && wr.tready) begin
            mem_data[wr_ptr[ADDR_BITS-1:0]] <= wr.tdata;
            mem_keep[wr_ptr[ADDR_BITS-1:0]] <= wr.tkeep;
            mem_last[wr_ptr[ADDR_BITS-1:0]] <= wr.tlast;
        end
    end

endmodule

`default_nettype wire

// File: source/pattern_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher #(
    parameter int DATA_BYTES = 8,
    parameter int PAT_BYTES = 4
) (
    input  logic                   aclk,
    input  logic                   aresetn,

    input  logic                   cfg_valid,
    output logic                   cfg_ready,
    input  logic [8*PAT_BYTES-1:0] cfg_pattern,

    stream_if.dst                  data_in,

    output logic                   found_valid,
    input  logic                   found_ready,
    output logic                   found
);

    // Tail kept from the previous beat, then the current beat on top
    localparam int WIN = PAT_BYTES - 1;
    localparam int CAT = WIN + DATA_BYTES;

    logic [8*PAT_BYTES-1:0] pattern;
    logic [8*WIN-1:0]       win_data;
    logic [WIN-1:0]         win_keep;
    logic [8*CAT-1:0]       cat_data;
    logic [CAT-1:0]         cat_keep;
    logic                   in_packet;
    logic                   hit;
    logic                   hit_now;
    logic                   beat;
    logic                   cfg_load;

    // Pattern changes only between packets
    assign cfg_ready = ~in_packet & ~found_valid;
    assign cfg_load = cfg_valid & cfg_ready;

    // Hold off input while a verdict waits or a pattern loads
    assign data_in.tready = ~found_valid & ~cfg_load;
    assign beat = data_in.tvalid & data_in.tready;

    // Older bytes in the low lanes
    assign cat_data = {data_in.tdata, win_data};
    assign cat_keep = {data_in.tkeep, win_keep};

    // Every alignment of the pattern over window and beat
    always_comb begin
        hit_now = 1'b0;
        for (int p = 0; p <= CAT - PAT_BYTES; p++) begin
            if ((&cat_keep[p +: PAT_BYTES]) &&
                (cat_data[8*p +: 8*PAT_BYTES] == pattern)) begin
                hit_now = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pattern <= '0;
            in_packet <= 1'b0;
            hit <= 1'b0;
            win_keep <= '0;
            found_valid <= 1'b0;
        end else begin
            if (cfg_load) begin
                pattern <= cfg_pattern;
            end
            if (found_valid && found_ready) begin
                found_valid <= 1'b0;
            end
            if (beat) begin
                if (data_in.tlast) begin
                    // Packet done, window starts empty for the next one
                    in_packet <= 1'b0;
                    hit <= 1'b0;
                    win_keep <= '0;
                    found_valid <= 1'b1;
                end else begin
                    in_packet <= 1'b1;
                    hit <= hit | hit_now;
                    win_keep <= cat_keep[CAT-1 -: WIN];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (beat) begin
            win_data <= cat_data[8*CAT-1 -: 8*WIN];
            if (data_in.tlast) begin
                found <= hit | hit_now;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/request_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module request_decoder #(
    parameter int DATA_BYTES = 8
) (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic [filter_pkg::VADDR_BITS-1:0] req_vaddr,
    input  logic [filter_pkg::LEN_BITS-1:0]   req_len,
    input  logic [filter_pkg::QP_BITS-1:0]    req_qp,
    request_if.src                           req
);
    import filter_pkg::*;

    localparam int BEAT_SHIFT = $clog2(DATA_BYTES);

    logic                accept;
    logic [LEN_BITS-1:0] len_minus_one;

    // Single slot, open only while empty
    assign req_ready = ~req.valid;
    assign accept = req_valid & req_ready;
    assign len_minus_one = req_len - 1'b1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            req.valid <= 1'b0;
        end else if (accept) begin
            req.valid <= 1'b1;
        end else if (req.valid && req.ready) begin
            req.valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            req.vaddr <= req_vaddr;
            req.len <= req_len;
            req.qp <= req_qp;
            // Beat index of the last byte
            req.last_beat <= len_minus_one[LEN_BITS-1:BEAT_SHIFT];
        end
    end

endmodule

`default_nettype wire

// File: source/request_if.sv
`timescale 1ns/1ps
`default_nettype none

interface request_if #(
    parameter int DATA_BYTES = 8
);
    import filter_pkg::*;

    // Index of the final beat, so the low address bits are dropped
    localparam int LAST_BITS = LEN_BITS - $clog2(DATA_BYTES);

    logic                  valid;
    logic                  ready;
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
    logic [QP_BITS-1:0]    qp;
    logic [LAST_BITS-1:0]  last_beat;

    modport src (output valid, vaddr, len, qp, last_beat, input ready);
    modport dst (input valid, vaddr, len, qp, last_beat, output ready);

endinterface

`default_nettype wire

// File: source/stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stream_if #(
    parameter int DATA_BYTES = 8
);
    logic                    tvalid;
    logic                    tready;
    logic [8*DATA_BYTES-1:0] tdata;
    logic [DATA_BYTES-1:0]   tkeep;
    logic                    tlast;

    // Beat moves when tvalid and tready are both high
    modport src (
        output tvalid, tdata, tkeep, tlast,
        input  tready
    );

    modport dst (
        input  tvalid, tdata, tkeep, tlast,
        output tready
    );

endinterface

`default_nettype wire

// File: source/filter_pkg.sv
`default_nettype none

package filter_pkg;

    // RDMA write command field widths
    localparam int VADDR_BITS = 48;
    localparam int LEN_BITS = 28;
    localparam int QP_BITS = 24;

    // Drop notice length, also its count of valid low bytes
    localparam int NOTICE_BYTES = 4;

    // Forwarding FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        SEND = 2'd1,
        DROP = 2'd2
    } fwd_state_t;

endpackage

`default_nettype wire
